// ==== dv/frontend_vectors.txt ====
# M group_addr data64 | E group_addr | T id redir start_pc stall wait count
# redir 1 jumps to start_pc, stall 1 randomizes the backend, wait 1 runs the idle lock
M 1c000000 040028a400001883
M 1c000008 0c00000008003065
M 1c000010 2800123410004c47
M 1c000018 07ffffff00007fff
M 1c000100 100024e2ffffffff
M 1c000108 0800148108002c43
M 1c002000 000020c40c000000
M 1c003000 04003c2100005d8b
M 1c003008 080008a2fc000001
E 1c003000
E 1c003008
T 1 0 1c000000 0 0 12
T 2 1 1c000104 0 0 10
T 3 0 1c00012c 1 0 40
T 4 1 1c002000 1 0 30
T 5 0 1c002078 0 1 16
T 6 1 1c003000 1 0 8

// ==== dv/tb_frontend.sv ====
`timescale 1ns/1ps

module tb_frontend import frontend_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES = 20;
    localparam int TEST_TIMEOUT = 2000;

    logic             clk;
    logic             rst_n;
    logic             redirect_valid_i;
    logic [31:0]      redirect_pc_i;
    logic             wait_i;
    logic             int_i;
    logic             bus_req_o;
    logic [31:0]      bus_addr_o;
    logic             bus_resp_valid_i;
    logic [63:0]      bus_resp_data_i;
    logic             bus_resp_err_i;
    logic [1:0]       inst_valid_o;
    logic [1:0][31:0] inst_pc_o;
    logic [1:0][31:0] inst_word_o;
    logic [1:0]       inst_err_o;
    reg_type_e [1:0]  inst_type_o;
    logic [1:0][4:0]  inst_rs0_o;
    logic [1:0][4:0]  inst_rs1_o;
    logic [1:0][4:0]  inst_rd_o;
    logic [1:0]       issue_num_i;
    logic             backend_stall_i;

    // bus memory model keyed by 8-byte group number
    logic [63:0]      mem_data [int unsigned];
    bit               err_groups [int unsigned];
    bit               resp_pending;
    int               resp_delay;
    logic [31:0]      resp_addr;

    int               t_id [$];
    int               t_redir [$];
    logic [31:0]      t_start [$];
    int               t_stall [$];
    int               t_wait [$];
    int               t_count [$];
    logic [31:0]      exp_pcs [$];

    int               seed;
    int               errors;
    int               test_errs;
    int               test_id;
    int               got;
    int               total_insts;
    int               tests_run;
    bit               aborted;

    frontend UUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // fill for unloaded groups walks the opcode classes word by word
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        logic [31:0] mix;
        mix = (addr * 32'h9e37_79b1) ^ (addr >> 13);
        return {3'b000, addr[4:2], mix[25:0]};
    endfunction

    function automatic logic [63:0] group_data(input logic [31:0] base);
        if (mem_data.exists(base >> 3) != 0) begin
            return mem_data[base >> 3];
        end
        return {fill_word(base | 32'd4), fill_word(base)};
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] pc);
        logic [63:0] d;
        d = group_data(pc & 32'hffff_fff8);
        return pc[2] ? d[63:32] : d[31:0];
    endfunction

    function automatic reg_type_e expected_type(input logic [31:0] w);
        case (w[31:26])
            6'b000000: return RRW;
            6'b000001: return RW;
            6'b000010: return RR;
            6'b000011: return BL;
            6'b000100: return W;
            default: return NONE;
        endcase
    endfunction

    // {rs0, rs1, rd}
    function automatic logic [14:0] expected_regs(input logic [31:0] w);
        case (expected_type(w))
            RRW, W: return {w[14:10], w[9:5], w[4:0]};
            RW: return {5'd0, w[9:5], w[4:0]};
            RR: return {w[4:0], w[9:5], 5'd0};
            BL: return {10'd0, 5'd1};
            default: return 15'd0;
        endcase
    endfunction

    task automatic note_error();
        errors++;
        test_errs++;
    endtask

    task automatic check_slot(input int slot);
        logic [31:0] pc;
        logic [31:0] w;
        logic [14:0] regs;
        logic        err;
        reg_type_e   t;
        string       exp_msg;
        pc = exp_pcs.pop_front();
        w = expected_word(pc);
        t = expected_type(w);
        regs = expected_regs(w);
        err = (err_groups.exists(pc >> 3) != 0);
        got++;
        total_insts++;
        assert (inst_pc_o[slot] == pc) else begin
            $display("MISMATCH at %0t: slot %0d pc %h, expected %h", $time, slot,
                     inst_pc_o[slot], pc);
            note_error();
        end
        assert (inst_word_o[slot] == w) else begin
            $display("MISMATCH at %0t: pc %h word %h, expected %h", $time, pc,
                     inst_word_o[slot], w);
            note_error();
        end
        assert (inst_err_o[slot] == err) else begin
            $display("MISMATCH at %0t: pc %h err %b, expected %b", $time, pc,
                     inst_err_o[slot], err);
            note_error();
        end
        assert (inst_type_o[slot] == t &&
                {inst_rs0_o[slot], inst_rs1_o[slot], inst_rd_o[slot]} == regs) else begin
            exp_msg = $sformatf("expected %0d %0d %0d %0d", t, regs[14:10], regs[9:5],
                                regs[4:0]);
            $display("MISMATCH at %0t: pc %h type %0d rs0 %0d rs1 %0d rd %0d, %s",
                     $time, pc, inst_type_o[slot], inst_rs0_o[slot], inst_rs1_o[slot],
                     inst_rd_o[slot], exp_msg);
            note_error();
        end
    endtask

    task automatic serve_bus();
        bus_resp_valid_i = 1'b0;
        bus_resp_err_i = 1'b0;
        if (resp_pending) begin
            if (resp_delay > 1) begin
                resp_delay--;
            end else begin
                bus_resp_valid_i = 1'b1;
                bus_resp_data_i = group_data(resp_addr);
                bus_resp_err_i = (err_groups.exists(resp_addr >> 3) != 0);
                resp_pending = 1'b0;
            end
        end
        if (rst_n && bus_req_o) begin
            assert (!resp_pending) else begin
                $display("bus request at %0t while another request was outstanding", $time);
                note_error();
            end
            assert (bus_addr_o[2:0] == 3'b000) else begin
                $display("MISMATCH at %0t: bus_addr_o %h, expected 8-byte aligned", $time,
                         bus_addr_o);
                note_error();
            end
            resp_pending = 1'b1;
            resp_addr = bus_addr_o;
            resp_delay = 1 + ({$random(seed)} % 4);
        end
    endtask

    // the slots picked here leave the queue at the next rising edge
    task automatic drive_backend(input bit allow_issue, input bit random_mode);
        int avail;
        int num;
        int r;
        bit stall;
        avail = inst_valid_o[1] ? 2 : (inst_valid_o[0] ? 1 : 0);
        stall = !allow_issue;
        num = 2;
        if (random_mode) begin
            r = $random(seed);
            stall = stall || (r[1:0] == 2'b00);
            num = {$random(seed)} % 3;
        end
        if (num > exp_pcs.size()) begin
            num = exp_pcs.size();
        end
        backend_stall_i = stall;
        issue_num_i = num[1:0];
        if (!stall) begin
            for (int i = 0; i < num && i < avail; i++) begin
                check_slot(i);
            end
        end
    endtask

    task automatic advance_cycle(input bit allow_issue, input bit random_mode);
        @(negedge clk);
        serve_bus();
        drive_backend(allow_issue, random_mode);
    endtask

    task automatic load_vectors();
        int               fd;
        int               code;
        int               id;
        int               redir;
        int               stall;
        int               wt;
        int               cnt;
        logic [7:0]       tag;
        logic [31:0]      a;
        logic [63:0]      d;
        logic [8*200-1:0] rest;
        fd = $fopen("dv/frontend_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file dv/frontend_vectors.txt");
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                break;
            end
            case (tag)
                "M": begin
                    code = $fscanf(fd, "%h %h", a, d);
                    mem_data[a >> 3] = d;
                end
                "E": begin
                    code = $fscanf(fd, "%h", a);
                    err_groups[a >> 3] = 1'b1;
                end
                "T": begin
                    code = $fscanf(fd, "%d %d %h %d %d %d", id, redir, a, stall, wt, cnt);
                    t_id.push_back(id);
                    t_redir.push_back(redir);
                    t_start.push_back(a);
                    t_stall.push_back(stall);
                    t_wait.push_back(wt);
                    t_count.push_back(cnt);
                end
                "#": code = $fgets(rest, fd);
                default: begin
                    $display("vector file has a line of unknown kind %c", tag);
                    aborted = 1'b1;
                end
            endcase
        end
        $fclose(fd);
        if (t_id.size() == 0) begin
            $display("vector file holds no test lines");
            aborted = 1'b1;
        end
    endtask

    task automatic run_test(input int idx);
        int cycles;
        bit rnd;
        test_id = t_id[idx];
        test_errs = 0;
        got = 0;
        rnd = (t_stall[idx] != 0);
        if (t_redir[idx] != 0) begin
            advance_cycle(1'b0, 1'b0);
            redirect_valid_i = 1'b1;
            redirect_pc_i = t_start[idx];
            exp_pcs.delete();
        end
        for (int k = 0; k < t_count[idx]; k++) begin
            exp_pcs.push_back(t_start[idx] + 32'(4 * k));
        end
        if (t_redir[idx] != 0) begin
            advance_cycle(1'b1, rnd);
            redirect_valid_i = 1'b0;
        end
        if (t_wait[idx] != 0) begin
            advance_cycle(1'b1, rnd);
            wait_i = 1'b1;
            advance_cycle(1'b1, rnd);
            wait_i = 1'b0;
            for (int c = 0; c < IDLE_CYCLES; c++) begin
                assert (bus_req_o == 1'b0) else begin
                    $display("MISMATCH at %0t: bus_req_o 1 while idle lock is set", $time);
                    note_error();
                end
                advance_cycle(1'b1, rnd);
            end
            int_i = 1'b1;
            advance_cycle(1'b1, rnd);
            int_i = 1'b0;
        end
        cycles = 0;
        while (exp_pcs.size() != 0 && cycles < TEST_TIMEOUT) begin
            advance_cycle(1'b1, rnd);
            cycles++;
        end
        if (exp_pcs.size() != 0) begin
            $display("test %0d timed out after %0d cycles, %0d instructions never arrived",
                     test_id, cycles, exp_pcs.size());
            note_error();
            aborted = 1'b1;
        end
        $display("test %0d: %0d instructions checked, %0d errors", test_id, got, test_errs);
    endtask

    initial begin
        rst_n = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i = 32'd0;
        wait_i = 1'b0;
        int_i = 1'b0;
        bus_resp_valid_i = 1'b0;
        bus_resp_data_i = 64'd0;
        bus_resp_err_i = 1'b0;
        issue_num_i = 2'd0;
        backend_stall_i = 1'b1;
        seed = 99942;
        errors = 0;
        test_errs = 0;
        total_insts = 0;
        tests_run = 0;
        aborted = 1'b0;
        resp_pending = 1'b0;
        load_vectors();
        repeat (RESET_CYCLES) advance_cycle(1'b0, 1'b0);
        assert (bus_req_o == 1'b0 && inst_valid_o == 2'b00) else begin
            $display("MISMATCH at %0t: bus_req_o %b inst_valid_o %b in reset, expected 0",
                     $time, bus_req_o, inst_valid_o);
            note_error();
        end
        rst_n = 1'b1;
        for (int i = 0; i < t_id.size() && !aborted; i++) begin
            run_test(i);
            tests_run++;
        end
        $display("tests %0d, instructions %0d, errors %0d", tests_run, total_insts, errors);
        if (errors == 0 && !aborted) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
rtl/frontend_pkg.sv
rtl/pc_gen.sv
rtl/fetch_unit.sv
rtl/multi_channel_fifo.sv
rtl/reg_decoder.sv
rtl/frontend.sv
dv/tb_frontend.sv

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import frontend_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,
    input  logic [31:0]            pc_i,
    input  logic                   pc_valid_i,
    output logic                   pc_take_o,
    input  logic                   queue_ready_i,
    output logic                   bus_req_o,
    output logic [31:0]            bus_addr_o,
    input  logic                   bus_resp_valid_i,
    input  logic [63:0]            bus_resp_data_i,
    input  logic                   bus_resp_err_i,
    output logic [1:0]             write_num_o,
    output fetch_entry_t [1:0]     write_data_o
);

    logic        outstanding;
    logic        stale;
    logic [31:0] req_pc;
    logic [31:0] group_base;
    logic        issue;
    logic        resp_good;
    logic        upper_only;

    // one request in flight at most
    assign issue = pc_valid_i && queue_ready_i && !outstanding && !flush_i;
    assign pc_take_o = issue;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_req_o <= 1'b0;
            outstanding <= 1'b0;
            stale <= 1'b0;
        end else begin
            bus_req_o <= issue;
            if (issue) begin
                outstanding <= 1'b1;
            end else if (bus_resp_valid_i) begin
                outstanding <= 1'b0;
            end
            if (bus_resp_valid_i) begin
                stale <= 1'b0;
            end else if (flush_i && outstanding) begin
                // answer still comes back, just gets dropped
                stale <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc <= pc_i;
            bus_addr_o <= {pc_i[31:3], 3'b000};
        end
    end

    assign group_base = {req_pc[31:3], 3'b000};
    assign upper_only = req_pc[2];
    assign resp_good = bus_resp_valid_i && outstanding && !stale && !flush_i;

    always_comb begin
        write_num_o = 2'd0;
        if (resp_good) begin
            write_num_o = upper_only ? 2'd1 : 2'd2;
        end
        // lone upper word goes into entry 0
        write_data_o[0].pc = upper_only ? (group_base | 32'd4) : group_base;
        write_data_o[0].word = upper_only ? bus_resp_data_i[63:32] : bus_resp_data_i[31:0];
        write_data_o[0].err = bus_resp_err_i;
        write_data_o[1].pc = group_base | 32'd4;
        write_data_o[1].word = bus_resp_data_i[63:32];
        write_data_o[1].err = bus_resp_err_i;
    end

endmodule

// ==== rtl/frontend.sv ====
`timescale 1ns/1ps

module frontend import frontend_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  redirect_valid_i,
    input  logic [31:0]           redirect_pc_i,
    input  logic                  wait_i,
    input  logic                  int_i,
    output logic                  bus_req_o,
    output logic [31:0]           bus_addr_o,
    input  logic                  bus_resp_valid_i,
    input  logic [63:0]           bus_resp_data_i,
    input  logic                  bus_resp_err_i,
    output logic [1:0]            inst_valid_o,
    output logic [1:0][31:0]      inst_pc_o,
    output logic [1:0][31:0]      inst_word_o,
    output logic [1:0]            inst_err_o,
    output reg_type_e [1:0]       inst_type_o,
    output logic [1:0][4:0]       inst_rs0_o,
    output logic [1:0][4:0]       inst_rs1_o,
    output logic [1:0][4:0]       inst_rd_o,
    input  logic [1:0]            issue_num_i,
    input  logic                  backend_stall_i
);

    logic [31:0]        fetch_pc;
    logic               fetch_pc_valid;
    logic               pc_take;
    logic [1:0]         raw_write_num;
    fetch_entry_t [1:0] raw_write_data;
    logic               raw_write_ready;
    logic [1:0]         raw_read_valid;
    fetch_entry_t [1:0] raw_read_data;
    dec_entry_t [1:0]   dec_write_data;
    logic [1:0]         dec_num;
    logic               dec_write_ready;
    dec_entry_t [1:0]   dec_read_data;

    pc_gen u_pc_gen (
        .clk              (clk),
        .rst_n            (rst_n),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .wait_i           (wait_i),
        .int_i            (int_i),
        .pc_take_i        (pc_take),
        .pc_o             (fetch_pc),
        .pc_valid_o       (fetch_pc_valid)
    );

    fetch_unit u_fetch_unit (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (redirect_valid_i),
        .pc_i             (fetch_pc),
        .pc_valid_i       (fetch_pc_valid),
        .pc_take_o        (pc_take),
        .queue_ready_i    (raw_write_ready),
        .bus_req_o        (bus_req_o),
        .bus_addr_o       (bus_addr_o),
        .bus_resp_valid_i (bus_resp_valid_i),
        .bus_resp_data_i  (bus_resp_data_i),
        .bus_resp_err_i   (bus_resp_err_i),
        .write_num_o      (raw_write_num),
        .write_data_o     (raw_write_data)
    );

    // raw fetch groups
    multi_channel_fifo #(
        .payload_t (fetch_entry_t),
        .DEPTH     (FETCH_FIFO_DEPTH)
    ) u_raw_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (redirect_valid_i),
        .write_num_i   (raw_write_num),
        .write_data_i  (raw_write_data),
        .write_ready_o (raw_write_ready),
        .read_valid_o  (raw_read_valid),
        .read_ready_i  (dec_write_ready),
        .read_num_i    (dec_num),
        .read_data_o   (raw_read_data)
    );

    reg_decoder u_reg_decoder (
        .raw_i       (raw_read_data),
        .raw_valid_i (raw_read_valid),
        .dec_o       (dec_write_data),
        .dec_num_o   (dec_num)
    );

    // decoded slots waiting for issue
    multi_channel_fifo #(
        .payload_t (dec_entry_t),
        .DEPTH     (DEC_FIFO_DEPTH)
    ) u_dec_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (redirect_valid_i),
        .write_num_i   (dec_num),
        .write_data_i  (dec_write_data),
        .write_ready_o (dec_write_ready),
        .read_valid_o  (inst_valid_o),
        .read_ready_i  (!backend_stall_i),
        .read_num_i    (issue_num_i),
        .read_data_o   (dec_read_data)
    );

    for (genvar i = 0; i < 2; i++) begin : g_out
        assign inst_pc_o[i] = dec_read_data[i].pc;
        assign inst_word_o[i] = dec_read_data[i].word;
        assign inst_err_o[i] = dec_read_data[i].err;
        assign inst_type_o[i] = dec_read_data[i].reg_type;
        assign inst_rs0_o[i] = dec_read_data[i].rs0;
        assign inst_rs1_o[i] = dec_read_data[i].rs1;
        assign inst_rd_o[i] = dec_read_data[i].rd;
    end

endmodule

// ==== rtl/frontend_pkg.sv ====
package frontend_pkg;

    // first fetch address out of reset
    localparam logic [31:0] RESET_PC = 32'h1c00_0000;

    // queue depths, in instruction slots
    localparam int FETCH_FIFO_DEPTH = 4;
    localparam int DEC_FIFO_DEPTH = 4;

    // major opcode, instruction bits 31..26
    localparam logic [5:0] OPC_RRW = 6'b000000;
    localparam logic [5:0] OPC_RW = 6'b000001;
    localparam logic [5:0] OPC_RR = 6'b000010;
    localparam logic [5:0] OPC_BL = 6'b000011;
    localparam logic [5:0] OPC_W = 6'b000100;

    // register usage class
    typedef enum logic [2:0] {
        NONE = 3'd0,
        RW = 3'd1,
        RRW = 3'd2,
        RR = 3'd3,
        BL = 3'd4,
        W = 3'd5
    } reg_type_e;

    // one raw slot, as it comes off the bus
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
        logic        err;
    } fetch_entry_t;

    // one decoded slot
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] word;
        logic        err;
        reg_type_e   reg_type;
        logic [4:0]  rs0;
        logic [4:0]  rs1;
        logic [4:0]  rd;
    } dec_entry_t;

endpackage

// ==== rtl/multi_channel_fifo.sv ====
`timescale 1ns/1ps

module multi_channel_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           flush_i,
    input  logic [1:0]     write_num_i,
    input  payload_t [1:0] write_data_i,
    output logic           write_ready_o,
    output logic [1:0]     read_valid_o,
    input  logic           read_ready_i,
    input  logic [1:0]     read_num_i,
    output payload_t [1:0] read_data_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int SUM_W = PTR_W + 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_nx1;
    logic [PTR_W-1:0] rd_ptr_nx1;
    logic [CNT_W-1:0] count;
    logic [1:0]       avail;
    logic [1:0]       wr_num;
    logic [1:0]       rd_num;

    // circular pointer step, wraps at DEPTH
    function automatic logic [PTR_W-1:0] ptr_add(
        input logic [PTR_W-1:0] p,
        input logic [1:0]       n
    );
        logic [SUM_W-1:0] sum;
        sum = {1'b0, p} + SUM_W'(n);
        if (sum >= SUM_W'(DEPTH)) begin
            sum = sum - SUM_W'(DEPTH);
        end
        return sum[PTR_W-1:0];
    endfunction

    assign wr_ptr_nx1 = ptr_add(wr_ptr, 2'd1);
    assign rd_ptr_nx1 = ptr_add(rd_ptr, 2'd1);

    // room for a full group of two
    assign write_ready_o = (count <= CNT_W'(DEPTH - 2));

    assign avail = (count >= CNT_W'(2)) ? 2'd2 : ((count == CNT_W'(1)) ? 2'd1 : 2'd0);
    assign read_valid_o = {avail[1], avail[1] | avail[0]};

    assign wr_num = write_ready_o ? write_num_i : 2'd0;
    assign rd_num = !read_ready_i ? 2'd0 : ((read_num_i > avail) ? avail : read_num_i);

    assign read_data_o[0] = mem[rd_ptr];
    assign read_data_o[1] = mem[rd_ptr_nx1];

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= ptr_add(wr_ptr, wr_num);
            rd_ptr <= ptr_add(rd_ptr, rd_num);
            count <= count + CNT_W'(wr_num) - CNT_W'(rd_num);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_num != 2'd0) begin
            mem[wr_ptr] <= write_data_i[0];
        end
        if (wr_num >= 2'd2) begin
            mem[wr_ptr_nx1] <= write_data_i[1];
        end
    end

endmodule

// ==== rtl/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen import frontend_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect_valid_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        wait_i,
    input  logic        int_i,
    input  logic        pc_take_i,
    output logic [31:0] pc_o,
    output logic        pc_valid_o
);

    logic [31:0] pc_q;
    logic        idle_lock;
    logic        running;
    logic        wait_req;

    assign wait_req = wait_i && !int_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (redirect_valid_i) begin
            pc_q <= redirect_pc_i;
        end else if (pc_take_i) begin
            // next group always starts 8-byte aligned
            pc_q <= {pc_q[31:3] + 29'd1, 3'b000};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idle_lock <= 1'b0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (wait_req) begin
                idle_lock <= 1'b1;
            end else if (int_i) begin
                idle_lock <= 1'b0;
            end
        end
    end

    assign pc_o = pc_q;
    // no new fetch in the cycle the wait arrives either
    assign pc_valid_o = running && !idle_lock && !wait_req;

endmodule

// ==== rtl/reg_decoder.sv ====
`timescale 1ns/1ps

module reg_decoder import frontend_pkg::*; (
    input  fetch_entry_t [1:0] raw_i,
    input  logic [1:0]         raw_valid_i,
    output dec_entry_t [1:0]   dec_o,
    output logic [1:0]         dec_num_o
);

    function automatic reg_type_e lookup_type(input logic [5:0] opcode);
        reg_type_e t;
        case (opcode)
            OPC_RRW: t = RRW;
            OPC_RW: t = RW;
            OPC_RR: t = RR;
            OPC_BL: t = BL;
            OPC_W: t = W;
            default: t = NONE;
        endcase
        return t;
    endfunction

    function automatic dec_entry_t decode_slot(input fetch_entry_t raw);
        dec_entry_t d;
        logic [4:0] f_rd;
        logic [4:0] f_rj;
        logic [4:0] f_rk;
        f_rd = raw.word[4:0];
        f_rj = raw.word[9:5];
        f_rk = raw.word[14:10];
        d.pc = raw.pc;
        d.word = raw.word;
        d.err = raw.err;
        d.reg_type = lookup_type(raw.word[31:26]);
        d.rs0 = 5'd0;
        d.rs1 = 5'd0;
        d.rd = 5'd0;
        case (d.reg_type)
            RRW, W: begin
                d.rs0 = f_rk;
                d.rs1 = f_rj;
                d.rd = f_rd;
            end
            RW: begin
                d.rs1 = f_rj;
                d.rd = f_rd;
            end
            RR: begin
                // stores and branches read rd as a source
                d.rs0 = f_rd;
                d.rs1 = f_rj;
            end
            BL: begin
                // link register is r1
                d.rd = 5'd1;
            end
            default: begin
                d.rd = 5'd0;
            end
        endcase
        return d;
    endfunction

    assign dec_o[0] = decode_slot(raw_i[0]);
    assign dec_o[1] = decode_slot(raw_i[1]);

    // popcount of the valid mask
    assign dec_num_o = {raw_valid_i[1] & raw_valid_i[0], raw_valid_i[1] ^ raw_valid_i[0]};

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -sv -f list.f --top-module tb_frontend -o tb_frontend \
    && ./obj_dir/tb_frontend > sim.log \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Result: PASSED" sim.log && exit 0 || exit 1
